//--- verilog.f
logic/encoder_pkg.sv
logic/stream_pkg.sv
logic/quadrature_decoder.sv
logic/angle_counter.sv
logic/speed_timer.sv
logic/encoder_control.sv
logic/encoder_interface.sv
bench/encoder_checker.sv
bench/encoder_interface_tb.sv

//--- Bender.yml
package:
  name: encoder_interface

sources:
  - files:
      - logic/encoder_pkg.sv
      - logic/stream_pkg.sv
      - logic/quadrature_decoder.sv
      - logic/angle_counter.sv
      - logic/speed_timer.sv
      - logic/encoder_control.sv
      - logic/encoder_interface.sv
  - target: test
    files:
      - bench/encoder_checker.sv
      - bench/encoder_interface_tb.sv

//--- bench/encoder_interface_tb.sv
// testbench for the encoder interface
// walks a table of shaft moves, samples angle and speed and checks the beats
// max_count is 1000, angle beats go to dest 47 and speed beats to dest 33
// table values assume the angle is zero after reset and rows run in order
// a row with a speed sample needs at least two steps at its spacing

`timescale 1ns/1ps

module encoder_interface_tb;

    localparam int NUM_ROWS = 7;

    // one shaft move and the beats it should produce
    typedef struct packed {
        logic [15:0]         steps;
        logic                dir_up;
        logic [7:0]          spacing;
        logic                z_pulse;
        logic                smp_angle;
        logic                smp_speed;
        logic                rand_ready;
        encoder_pkg::angle_t exp_angle;
        stream_pkg::word_t   exp_speed;
    } row_t;

    logic                     clock;
    logic                     rst_n;
    logic                     a;
    logic                     b;
    logic                     z;
    logic                     sample_angle;
    logic                     sample_speed;
    logic                     cfg_valid;
    logic                     cfg_ready;
    stream_pkg::reg_write_t   cfg;
    logic                     out_valid;
    logic                     out_ready = 1'b1;
    stream_pkg::stream_beat_t out;

    // expected beat feed
    logic                     push;
    stream_pkg::stream_beat_t push_beat;
    logic                     check_end;
    int                       errors;
    int                       beats;
    int                       outstanding;

    row_t   rows [NUM_ROWS];
    int     pos;
    int     cycle_count;
    int     cycle_limit;
    int     hold;
    logic   rand_ready_on;
    integer seed = 32'haece795d;

    encoder_interface UUT (
        .clock(clock), .rst_n(rst_n), .a(a), .b(b), .z(z),
        .sample_angle(sample_angle), .sample_speed(sample_speed),
        .cfg_valid(cfg_valid), .cfg(cfg), .cfg_ready(cfg_ready),
        .out_valid(out_valid), .out(out), .out_ready(out_ready)
    );

    encoder_checker chk (
        .clock(clock), .rst_n(rst_n), .push(push), .push_beat(push_beat),
        .check_end(check_end), .out_valid(out_valid), .out_ready(out_ready),
        .out(out), .errors(errors), .beats(beats), .outstanding(outstanding)
    );

    always #5 clock = ~clock;

    // run limit from the table length
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run went past %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    // back-pressure drops ready for 1 to 6 clocks about half the time
    always @(negedge clock) begin
        if (!rand_ready_on) begin
            out_ready = 1'b1;
            hold = 0;
        end else if (hold > 0) begin
            out_ready = 1'b0;
            hold--;
        end else begin
            out_ready = 1'b1;
            if ($random(seed) & 1) begin
                hold = 1 + ({$random(seed)} % 6);
            end
        end
    end

    // forward order of {a, b}
    function automatic logic [1:0] gray_ab(input int p);
        case (p)
            0:       return 2'b00;
            1:       return 2'b10;
            2:       return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    task automatic write_reg(input stream_pkg::reg_addr_t addr, input stream_pkg::word_t data);
        while (!cfg_ready) @(negedge clock);
        cfg_valid = 1'b1;
        cfg.addr  = addr;
        cfg.data  = data;
        @(negedge clock);
        cfg_valid = 1'b0;
    endtask

    task automatic expect_beat(input encoder_pkg::dest_t dest, input stream_pkg::word_t data);
        push           = 1'b1;
        push_beat.dest = dest;
        push_beat.data = data;
        @(negedge clock);
        push = 1'b0;
    endtask

    task automatic run_row(input row_t r);
        int drain;
        for (int s = 0; s < r.steps; s++) begin
            pos    = r.dir_up ? (pos + 1) % 4 : (pos + 3) % 4;
            {a, b} = gray_ab(pos);
            repeat (r.spacing) @(negedge clock);
        end
        if (r.z_pulse) begin
            z = 1'b1;
            repeat (2) @(negedge clock);
            z = 1'b0;
        end
        // synchronizer, decoder and counter settle
        repeat (8) @(negedge clock);
        rand_ready_on = r.rand_ready;
        if (r.smp_angle) expect_beat(8'd47, 32'(r.exp_angle));
        if (r.smp_speed) expect_beat(8'd33, r.exp_speed);
        sample_angle = r.smp_angle;
        sample_speed = r.smp_speed;
        @(negedge clock);
        sample_angle = 1'b0;
        sample_speed = 1'b0;
        // all beats of the row out before the next one
        // beats still queued after the drain window show up as missing
        drain = 0;
        while (outstanding != 0 && drain < 25) begin
            @(negedge clock);
            drain++;
        end
        rand_ready_on = 1'b0;
    endtask

    initial begin
        clock = 1'b0;
        rst_n = 1'b0;
        a = 1'b0;
        b = 1'b0;
        z = 1'b0;
        sample_angle = 1'b0;
        sample_speed = 1'b0;
        cfg_valid = 1'b0;
        cfg = '0;
        push = 1'b0;
        push_beat = '0;
        check_end = 1'b0;
        rand_ready_on = 1'b0;
        hold = 0;
        pos = 0;
        cycle_count = 0;

        // steps dir spacing z angle speed rand exp_angle exp_speed
        rows[0] = '{16'd5,   1'b1, 8'd10, 1'b0, 1'b1, 1'b1, 1'b0, 16'd5,   32'h8000_000a};
        // 5 - 12 wraps below zero
        rows[1] = '{16'd12,  1'b0, 8'd8,  1'b0, 1'b1, 1'b1, 1'b1, 16'd993, 32'h0000_0008};
        // index clears the angle after the steps
        rows[2] = '{16'd20,  1'b1, 8'd12, 1'b1, 1'b1, 1'b0, 1'b0, 16'd0,   32'h8000_000c};
        rows[3] = '{16'd3,   1'b1, 8'd9,  1'b0, 1'b1, 1'b1, 1'b1, 16'd3,   32'h8000_0009};
        // 3 + 999 wraps past max_count
        rows[4] = '{16'd999, 1'b1, 8'd8,  1'b0, 1'b1, 1'b1, 1'b0, 16'd2,   32'h8000_0008};
        rows[5] = '{16'd4,   1'b0, 8'd15, 1'b0, 1'b0, 1'b1, 1'b0, 16'd998, 32'h0000_000f};
        rows[6] = '{16'd2,   1'b1, 8'd8,  1'b0, 1'b1, 1'b1, 1'b1, 16'd0,   32'h8000_0008};

        cycle_limit = 200;
        foreach (rows[i]) cycle_limit += rows[i].steps * rows[i].spacing + 40;

        repeat (3) @(negedge clock);
        rst_n = 1'b1;
        write_reg(stream_pkg::REG_ANGLE_DEST, 32'd47);
        write_reg(stream_pkg::REG_SPEED_DEST, 32'd33);
        write_reg(stream_pkg::REG_MAX_COUNT, 32'd1000);

        foreach (rows[i]) run_row(rows[i]);

        check_end = 1'b1;
        repeat (2) @(negedge clock);
        $display("encoder checks done: %0d beats compared, %0d errors", beats, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- bench/encoder_checker.sv
// compares every transfer on the encoder output stream with an expected queue
// expected beats arrive one per clock on push and push_beat
// a transfer with nothing queued counts as an extra beat
// beats still queued when check_end rises count as missing

`timescale 1ns/1ps

module encoder_checker (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     push,
    input  stream_pkg::stream_beat_t push_beat,
    input  logic                     check_end,
    input  logic                     out_valid,
    input  logic                     out_ready,
    input  stream_pkg::stream_beat_t out,
    output int                       errors,
    output int                       beats,
    output int                       outstanding
);

    // beats the bench expects, oldest first
    stream_pkg::stream_beat_t exp_q[$];
    stream_pkg::stream_beat_t head;
    logic                     end_seen;

    always @(posedge clock) begin
        if (!rst_n) begin
            exp_q.delete();
            errors   = 0;
            beats    = 0;
            end_seen = 1'b0;
        end else begin
            // queue first so a push never looks like an extra beat
            if (push) begin
                exp_q.push_back(push_beat);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("extra beat at %0t: dest %0d data %h arrived with none expected",
                             $time, out.dest, out.data);
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    beats++;
                    if (out.dest !== head.dest) begin
                        $display("FAILED at %0t: out.dest expected %0d actual %0d",
                                 $time, head.dest, out.dest);
                        errors++;
                    end
                    if (out.data !== head.data) begin
                        $display("FAILED at %0t: out.data expected %h actual %h",
                                 $time, head.data, out.data);
                        errors++;
                    end
                end
            end
            if (check_end && !end_seen) begin
                end_seen = 1'b1;
                if (exp_q.size() != 0) begin
                    $display("missing beats: %0d expected beats never came out", exp_q.size());
                    errors += exp_q.size();
                end
            end
        end
        outstanding = exp_q.size();
    end

endmodule

//--- logic/encoder_interface.sv
// incremental encoder interface top level
// a, b and z are asynchronous; sample strobes are synchronous to clock
// ANGLE_W and PERIOD_W must match the encoder_pkg types
// the configuration struct and the speed word are built on those types

`timescale 1ns/1ps

module encoder_interface #(
    parameter int ANGLE_W  = encoder_pkg::ANGLE_W,
    parameter int PERIOD_W = encoder_pkg::PERIOD_W
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     a,
    input  logic                     b,
    input  logic                     z,
    input  logic                     sample_angle,
    input  logic                     sample_speed,
    input  logic                     cfg_valid,
    input  stream_pkg::reg_write_t   cfg,
    output logic                     cfg_ready,
    output logic                     out_valid,
    output stream_pkg::stream_beat_t out,
    input  logic                     out_ready
);

    // decoder pulses
    logic step_up;
    logic step_down;
    logic index;

    // measurements toward control
    logic [ANGLE_W-1:0]    angle;
    logic [PERIOD_W-1:0]   period;
    logic                  direction;
    encoder_pkg::enc_cfg_t enc_cfg;

    // overrides that break the package types
    if (ANGLE_W != $bits(encoder_pkg::angle_t)) begin : g_angle_w_check
        $error("ANGLE_W must equal the width of encoder_pkg::angle_t");
    end
    if (PERIOD_W != $bits(encoder_pkg::period_t)) begin : g_period_w_check
        $error("PERIOD_W must equal the width of encoder_pkg::period_t");
    end

    quadrature_decoder u_decoder (
        .clock     (clock),
        .rst_n     (rst_n),
        .a         (a),
        .b         (b),
        .z         (z),
        .step_up   (step_up),
        .step_down (step_down),
        .index     (index)
    );

    angle_counter #(.ANGLE_W(ANGLE_W)) u_angle (
        .clock     (clock),
        .rst_n     (rst_n),
        .step_up   (step_up),
        .step_down (step_down),
        .index     (index),
        .max_count (enc_cfg.max_count),
        .angle     (angle)
    );

    speed_timer #(.PERIOD_W(PERIOD_W)) u_speed (
        .clock     (clock),
        .rst_n     (rst_n),
        .step_up   (step_up),
        .step_down (step_down),
        .period    (period),
        .direction (direction)
    );

    encoder_control #(.ANGLE_W(ANGLE_W)) u_control (
        .clock        (clock),
        .rst_n        (rst_n),
        .cfg_valid    (cfg_valid),
        .cfg          (cfg),
        .cfg_ready    (cfg_ready),
        .enc_cfg      (enc_cfg),
        .sample_angle (sample_angle),
        .sample_speed (sample_speed),
        .angle        (angle),
        .period       (period),
        .direction    (direction),
        .out_valid    (out_valid),
        .out          (out),
        .out_ready    (out_ready)
    );

endmodule

//--- logic/encoder_control.sv
// configuration registers, sample capture and the output stream FSM
// one write per clock is accepted; there is no read-back
// a sample strobe is latched at once and its beat is valid the next clock
// both strobes together send angle first, then speed
// a repeated strobe while its kind is pending overwrites the latched value
// beats hold stable under back-pressure while sampling continues

`timescale 1ns/1ps

module encoder_control #(
    parameter int ANGLE_W = encoder_pkg::ANGLE_W
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     cfg_valid,
    input  stream_pkg::reg_write_t   cfg,
    output logic                     cfg_ready,
    output encoder_pkg::enc_cfg_t    enc_cfg,
    input  logic                     sample_angle,
    input  logic                     sample_speed,
    input  logic [ANGLE_W-1:0]       angle,
    input  encoder_pkg::period_t     period,
    input  logic                     direction,
    output logic                     out_valid,
    output stream_pkg::stream_beat_t out,
    input  logic                     out_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_send_angle,
        st_send_speed
    } state_t;

    state_t state;

    // samples waiting for the output register
    logic angle_pend;
    logic speed_pend;

    // latched sample words
    stream_pkg::word_t angle_q;
    stream_pkg::word_t speed_q;

    // word to send, live value when the strobe is present
    stream_pkg::word_t angle_word;
    stream_pkg::word_t speed_word;

    logic load_slot;
    logic angle_req;
    logic speed_req;
    logic pick_angle;
    logic pick_speed;

    // register writes
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cfg_ready <= 1'b0;
            enc_cfg   <= '0;
        end else begin
            cfg_ready <= 1'b1;
            if (cfg_valid && cfg_ready) begin
                case (cfg.addr)
                    stream_pkg::REG_ANGLE_DEST:
                        enc_cfg.angle_dest <= encoder_pkg::dest_t'(cfg.data);
                    stream_pkg::REG_SPEED_DEST:
                        enc_cfg.speed_dest <= encoder_pkg::dest_t'(cfg.data);
                    stream_pkg::REG_MAX_COUNT:
                        enc_cfg.max_count <= encoder_pkg::angle_t'(cfg.data);
                    default: ;
                endcase
            end
        end
    end

    // angle zero-extended
    assign angle_word = sample_angle ? stream_pkg::word_t'(angle) : angle_q;

    // direction in bit 31, period in the low bits
    assign speed_word = sample_speed
        ? {direction, {(31 - $bits(encoder_pkg::period_t)){1'b0}}, period}
        : speed_q;

    // output register free this clock
    assign load_slot = (state == st_idle) || (out_valid && out_ready);

    assign angle_req = sample_angle || angle_pend;
    assign speed_req = sample_speed || speed_pend;

    // after an angle beat a waiting speed sample goes next
    assign pick_speed = speed_req && (!angle_req || state == st_send_angle);
    assign pick_angle = angle_req && !pick_speed;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            angle_pend <= 1'b0;
            speed_pend <= 1'b0;
        end else begin
            angle_pend <= angle_req && !(load_slot && pick_angle);
            speed_pend <= speed_req && !(load_slot && pick_speed);
            if (load_slot) begin
                if (pick_angle) begin
                    state <= st_send_angle;
                end else if (pick_speed) begin
                    state <= st_send_speed;
                end else begin
                    state <= st_idle;
                end
            end
        end
    end

    // sample latches and the beat register
    always_ff @(posedge clock) begin
        angle_q <= angle_word;
        speed_q <= speed_word;
        if (load_slot && pick_angle) begin
            out <= '{dest: enc_cfg.angle_dest, data: angle_word};
        end else if (load_slot && pick_speed) begin
            out <= '{dest: enc_cfg.speed_dest, data: speed_word};
        end
    end

    assign out_valid = (state != st_idle);

    // stream rule seen by the consumer
    a_out_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out)
    ) else $error("output beat changed under back-pressure");

endmodule

//--- logic/speed_timer.sv
// measures clocks between encoder steps and the direction of the last step
// period stays all ones until two steps have been seen after reset
// the running count saturates at all ones and then reports a stopped shaft
// no averaging over several steps

`timescale 1ns/1ps

module speed_timer #(
    parameter int PERIOD_W = encoder_pkg::PERIOD_W
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                step_up,
    input  logic                step_down,
    output logic [PERIOD_W-1:0] period,
    output logic                direction
);

    // clocks since the last step
    logic [PERIOD_W-1:0] run_count;
    // first step seen, so the next one gives a real period
    logic                armed;
    logic                step;

    assign step = step_up | step_down;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            run_count <= '0;
            armed     <= 1'b0;
            period    <= '1;
            direction <= 1'b0;
        end else if (step) begin
            // restart at 1 so the step clock itself is counted
            run_count <= {{(PERIOD_W-1){1'b0}}, 1'b1};
            armed     <= 1'b1;
            direction <= step_up;
            // count since reset is meaningless before the first step
            period    <= armed ? run_count : '1;
        end else if (run_count != '1) begin
            run_count <= run_count + 1'b1;
        end else begin
            // shaft stopped long enough to saturate
            period <= '1;
        end
    end

endmodule

//--- logic/angle_counter.sv
// wrapping up/down angle counter with reset on the index pulse
// counts 0 .. max_count-1; max_count of zero means the full range
// index beats a step in the same clock
// the range assertion flags a max_count written below the current angle

`timescale 1ns/1ps

module angle_counter #(
    parameter int ANGLE_W = encoder_pkg::ANGLE_W
) (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               step_up,
    input  logic               step_down,
    input  logic               index,
    input  logic [ANGLE_W-1:0] max_count,
    output logic [ANGLE_W-1:0] angle
);

    // highest legal angle
    logic [ANGLE_W-1:0] top_val;

    // zero wraps as if max_count were 2^ANGLE_W
    assign top_val = (max_count == '0) ? '1 : max_count - 1'b1;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            angle <= '0;
        end else if (index) begin
            angle <= '0;
        end else if (step_up) begin
            // >= also pulls back an angle left out of range by a config write
            if (angle >= top_val) begin
                angle <= '0;
            end else begin
                angle <= angle + 1'b1;
            end
        end else if (step_down) begin
            if (angle == '0 || angle > top_val) begin
                angle <= top_val;
            end else begin
                angle <= angle - 1'b1;
            end
        end
    end

    // angle stays inside the configured range
    a_angle_in_range: assert property (
        @(posedge clock) disable iff (!rst_n)
        (max_count != '0) |-> (angle < max_count)
    ) else $error("angle %0d outside max_count %0d", angle, max_count);

endmodule

//--- logic/quadrature_decoder.sv
// quadrature decoder for an incremental encoder
// a, b and z are asynchronous and only pass a two-flop synchronizer
// there is no glitch filter
// a leading b counts up; both lines changing in one clock is dropped
// step and index pulses come three clocks after the line edge
// lines are expected to rest at a = b = 0 when reset is released

`timescale 1ns/1ps

module quadrature_decoder (
    input  logic clock,
    input  logic rst_n,
    input  logic a,
    input  logic b,
    input  logic z,
    output logic step_up,
    output logic step_down,
    output logic index
);

    // two synchronizer stages holding {z, a, b}
    logic [2:0] sync_1;
    logic [2:0] sync_2;

    // previous synchronized state
    logic [1:0] ab_prev;
    logic       z_prev;

    // current {a, b} after the synchronizer
    logic [1:0] ab_now;
    logic [1:0] ab_diff;
    logic       single_change;
    logic       dir_up;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= {z, a, b};
            sync_2 <= sync_1;
        end
    end

    assign ab_now  = sync_2[1:0];
    assign ab_diff = ab_now ^ ab_prev;

    // exactly one line moved
    // two lines moving xor to zero and are ignored
    assign single_change = ^ab_diff;

    // up order is 00 10 11 01
    // new a differs from old b only on forward transitions
    assign dir_up = ab_now[1] ^ ab_prev[0];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ab_prev   <= '0;
            z_prev    <= 1'b0;
            step_up   <= 1'b0;
            step_down <= 1'b0;
            index     <= 1'b0;
        end else begin
            ab_prev   <= ab_now;
            z_prev    <= sync_2[2];
            step_up   <= single_change & dir_up;
            step_down <= single_change & ~dir_up;
            // rising edge of z only
            index     <= sync_2[2] & ~z_prev;
        end
    end

    // counter and timer rely on exclusive steps
    a_one_step_dir: assert property (
        @(posedge clock) disable iff (!rst_n) !(step_up && step_down)
    ) else $error("step_up and step_down high together");

endmodule

//--- logic/stream_pkg.sv
// bus-level types for the configuration write port and the output stream
// register space has no read-back
// address 3 is accepted and discarded

package stream_pkg;

    // data word on both the write port and the output stream
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    // register address
    typedef logic [1:0] reg_addr_t;

    // register map
    localparam reg_addr_t REG_ANGLE_DEST = 2'd0;
    localparam reg_addr_t REG_SPEED_DEST = 2'd1;
    localparam reg_addr_t REG_MAX_COUNT  = 2'd2;

    // one register write, 34 bits
    typedef struct packed {
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

    // one output beat, 40 bits
    typedef struct packed {
        encoder_pkg::dest_t dest;
        word_t              data;
    } stream_beat_t;

endpackage

//--- logic/encoder_pkg.sv
// encoder-domain widths and types shared by the datapath and the control block
// angle_t and period_t are fixed at the default widths below
// a top level that overrides ANGLE_W or PERIOD_W must keep them equal to these
// enc_cfg_t is 32 bits and matches the register layout of the write port

package encoder_pkg;

    // default angle count width
    localparam int ANGLE_W = 16;

    // default width of the clocks-per-step measurement
    localparam int PERIOD_W = 24;

    // width of the routing code carried on each output beat
    localparam int DEST_W = 8;

    // shaft angle in encoder counts
    typedef logic [ANGLE_W-1:0] angle_t;

    // clocks between two steps
    // all ones means stopped or saturated
    typedef logic [PERIOD_W-1:0] period_t;

    // destination code on the output stream
    typedef logic [DEST_W-1:0] dest_t;

    // configuration held by the control block
    // max_count of zero selects the full 2^ANGLE_W range
    typedef struct packed {
        dest_t  angle_dest;
        dest_t  speed_dest;
        angle_t max_count;
    } enc_cfg_t;

endpackage
